// ==== hw/pipe_trace_pkg.sv ====
`default_nettype none

package pipe_trace_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////////////////////

    localparam int NUM_STAGES  = 5;
    localparam int STAMP_DEPTH = 8;
    localparam int FIFO_DEPTH  = 8;
    localparam int STAMP_AW    = $clog2(STAMP_DEPTH);
    localparam int FIFO_AW     = $clog2(FIFO_DEPTH);

    // stage positions in the stage array
    localparam int ST_F = 0;
    localparam int ST_D = 1;
    localparam int ST_E = 2;
    localparam int ST_M = 3;
    localparam int ST_W = 4;

    ////////////////////////////////////////////////////////////////////////////
    // vector types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [15:0]        cycle_t;
    typedef logic [7:0]         seq_t;
    typedef logic [15:0]        instr_t;
    typedef logic [7:0]         dwell_t;
    typedef logic [FIFO_AW:0]   level_t;
    typedef logic [FIFO_AW-1:0] fifo_ptr_t;
    typedef logic [STAMP_AW-1:0] stamp_idx_t;
    typedef logic [7:0]         drop_t;
    typedef logic [4:0]         apb_addr_t;
    typedef logic [31:0]        apb_data_t;

    localparam dwell_t DWELL_MAX = 8'hff;
    localparam drop_t  DROP_MAX  = 8'hff;

    ////////////////////////////////////////////////////////////////////////////
    // register map
    ////////////////////////////////////////////////////////////////////////////

    localparam apb_addr_t ADDR_CTRL   = 5'h00;
    localparam apb_addr_t ADDR_STATUS = 5'h04;
    localparam apb_addr_t ADDR_REC0   = 5'h08;
    localparam apb_addr_t ADDR_REC1   = 5'h0c;
    localparam apb_addr_t ADDR_REC2   = 5'h10;

    // control register bits
    localparam int CTRL_EN_BIT  = 0;
    localparam int CTRL_CLR_BIT = 1;

    // one pipeline slot, 25 bits
    typedef struct packed {
        logic   valid;
        seq_t   seq;
        instr_t instr;
    } stage_t;

    // one retired instruction, 88 bits
    typedef struct packed {
        seq_t   seq;
        instr_t instr;
        cycle_t fetch_cycle;
        cycle_t retire_cycle;
        dwell_t dwell_f;
        dwell_t dwell_d;
        dwell_t dwell_e;
        dwell_t dwell_m;
    } trace_rec_t;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

// ==== hw/stage_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module stage_pipe import pipe_trace_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   stall,
    input  logic   flush,
    input  logic   instr_valid,
    input  instr_t instr_word,
    output logic   instr_ready,
    output stage_t stages [NUM_STAGES],
    output logic   advance
);

    seq_t   seq_q;
    logic   load;
    stage_t fetch_in;

    // stall freezes everything, including the feed
    assign advance     = !stall;
    assign instr_ready = !stall;
    assign load        = instr_valid && !stall;

    always_comb begin
        fetch_in.valid = load;
        fetch_in.seq   = seq_q;
        fetch_in.instr = instr_word;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_STAGES; i++) begin
                stages[i].valid <= 1'b0;
            end
        end else if (advance) begin
            // a new word may enter fetch even while flushing
            stages[ST_F] <= fetch_in;

            if (flush) begin
                // old fetch and decode items are dropped
                stages[ST_D].valid <= 1'b0;
                stages[ST_E].valid <= 1'b0;
            end else begin
                stages[ST_D] <= stages[ST_F];
                stages[ST_E] <= stages[ST_D];
            end

            // memory and write-back always move on
            stages[ST_M] <= stages[ST_E];
            stages[ST_W] <= stages[ST_M];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // sequence ids
    ////////////////////////////////////////////////////////////////////////////

    // flushed words keep their id, so retired ids show gaps
    always_ff @(posedge clk) begin
        if (rst) begin
            seq_q <= '0;
        end else if (load) begin
            seq_q <= seq_q + seq_t'(1);
        end
    end

endmodule

`default_nettype wire

// ==== hw/trace_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module trace_unit import pipe_trace_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       enable,
    input  stage_t     stages [NUM_STAGES],
    input  logic       advance,
    output logic       rec_valid,
    output trace_rec_t rec
);

    cycle_t                cycle_q;
    logic                  adv_q;
    logic [NUM_STAGES-1:0] entered;
    stamp_idx_t            wb_idx;
    cycle_t                stamp_mem [STAMP_DEPTH][NUM_STAGES];
    cycle_t                stamps [NUM_STAGES];
    dwell_t                dwells [NUM_STAGES-1];

    function automatic dwell_t sat_dwell(cycle_t from, cycle_t to);
        cycle_t diff;
        diff = to - from;
        if (diff > cycle_t'(DWELL_MAX)) begin
            return DWELL_MAX;
        end
        return dwell_t'(diff);
    endfunction

    // free-running, wraps at 16 bits
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_q <= '0;
        end else begin
            cycle_q <= cycle_q + cycle_t'(1);
        end
    end

    // remembers whether the last edge shifted the pipe
    always_ff @(posedge clk) begin
        if (rst) begin
            adv_q <= 1'b0;
        end else begin
            adv_q <= advance;
        end
    end

    // a valid slot right after a shift holds a freshly loaded instruction,
    // and the counter now reads the value of that load edge
    always_comb begin
        for (int i = 0; i < NUM_STAGES; i++) begin
            entered[i] = adv_q && stages[i].valid;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stamp table, one entry per in-flight seq
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_STAGES; i++) begin
            if (entered[i]) begin
                stamp_mem[stages[i].seq[STAMP_AW-1:0]][i] <= cycle_q;
            end
        end
    end

    assign wb_idx = stages[ST_W].seq[STAMP_AW-1:0];

    always_comb begin
        for (int i = 0; i < NUM_STAGES; i++) begin
            stamps[i] = stamp_mem[wb_idx][i];
        end
        // write-back stamp lands in the table on this same edge
        stamps[ST_W] = cycle_q;
    end

    always_comb begin
        for (int i = 0; i < NUM_STAGES - 1; i++) begin
            dwells[i] = sat_dwell(stamps[i], stamps[i+1]);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // record assembly
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rec_valid <= 1'b0;
        end else begin
            rec_valid <= entered[ST_W] && enable;
        end
    end

    always_ff @(posedge clk) begin
        if (entered[ST_W]) begin
            rec.seq          <= stages[ST_W].seq;
            rec.instr        <= stages[ST_W].instr;
            rec.fetch_cycle  <= stamps[ST_F];
            rec.retire_cycle <= stamps[ST_W];
            rec.dwell_f      <= dwells[ST_F];
            rec.dwell_d      <= dwells[ST_D];
            rec.dwell_e      <= dwells[ST_E];
            rec.dwell_m      <= dwells[ST_M];
        end
    end

endmodule

`default_nettype wire

// ==== hw/trace_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module trace_fifo import pipe_trace_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       push,
    input  trace_rec_t push_rec,
    input  logic       pop,
    input  logic       clear,
    output trace_rec_t head,
    output level_t     level,
    output logic       empty,
    output drop_t      drop_count
);

    trace_rec_t mem [FIFO_DEPTH];
    fifo_ptr_t  wr_ptr;
    fifo_ptr_t  rd_ptr;
    logic       full;
    logic       do_push;
    logic       do_pop;

    assign empty   = (level == '0);
    assign full    = (level == level_t'(FIFO_DEPTH));
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push && !clear) begin
            mem[wr_ptr] <= push_rec;
        end
    end

    // clear wins over push and pop
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            level      <= '0;
            drop_count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + fifo_ptr_t'(1);
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + fifo_ptr_t'(1);
            end
            level <= level + level_t'(do_push) - level_t'(do_pop);

            // no back-pressure, a record meeting a full FIFO is lost
            if (push && full && drop_count != DROP_MAX) begin
                drop_count <= drop_count + drop_t'(1);
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/trace_apb.sv ====
`timescale 1ns/1ps
`default_nettype none

module trace_apb import pipe_trace_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  apb_req_t   req,
    input  trace_rec_t head,
    input  level_t     level,
    input  logic       empty,
    input  drop_t      drop_count,
    output apb_rsp_t   rsp,
    output logic       enable,
    output logic       pop,
    output logic       clear
);

    logic      access;
    logic      rd;
    logic      wr;
    logic      hit;
    logic      rec_sel;
    logic      rec_err;
    apb_data_t rd_data;

    // zero wait states, everything resolves in the access phase
    assign access = req.psel && req.penable;
    assign rd     = access && !req.pwrite;
    assign wr     = access && req.pwrite;

    ////////////////////////////////////////////////////////////////////////////
    // address decode and read mux
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        rd_data = '0;
        hit     = 1'b1;
        rec_sel = 1'b0;
        case (req.paddr)
            ADDR_CTRL: begin
                rd_data[CTRL_EN_BIT] = enable;
            end
            ADDR_STATUS: begin
                rd_data = {16'h0000, drop_count, 4'h0, level};
            end
            ADDR_REC0: begin
                rec_sel = 1'b1;
                rd_data = {head.seq, 8'h00, head.instr};
            end
            ADDR_REC1: begin
                rec_sel = 1'b1;
                rd_data = {head.fetch_cycle, head.retire_cycle};
            end
            ADDR_REC2: begin
                rec_sel = 1'b1;
                rd_data = {head.dwell_f, head.dwell_d, head.dwell_e, head.dwell_m};
            end
            default: begin
                hit = 1'b0;
            end
        endcase
    end

    // record read with nothing queued
    assign rec_err = rd && rec_sel && empty;

    always_comb begin
        rsp.pready  = 1'b1;
        rsp.pslverr = access && (!hit || rec_err);
        rsp.prdata  = (rd && hit && !rec_err) ? rd_data : '0;
    end

    ////////////////////////////////////////////////////////////////////////////
    // control bit and pulses
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            enable <= 1'b0;
            pop    <= 1'b0;
            clear  <= 1'b0;
        end else begin
            // reading the last record word retires the head
            pop   <= rd && (req.paddr == ADDR_REC2) && !empty;
            clear <= wr && (req.paddr == ADDR_CTRL) && req.pwdata[CTRL_CLR_BIT];
            if (wr && req.paddr == ADDR_CTRL) begin
                enable <= req.pwdata[CTRL_EN_BIT];
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/pipe_trace_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_trace_top import pipe_trace_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     stall,
    input  logic     flush,
    input  logic     instr_valid,
    input  instr_t   instr_word,
    input  apb_req_t apb_req,
    output logic     instr_ready,
    output apb_rsp_t apb_rsp
);

    stage_t     stages [NUM_STAGES];
    logic       advance;
    logic       enable;
    logic       rec_valid;
    trace_rec_t rec;
    trace_rec_t head;
    level_t     level;
    logic       empty;
    drop_t      drop_count;
    logic       pop;
    logic       clear;

    stage_pipe u_pipe (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .flush       (flush),
        .instr_valid (instr_valid),
        .instr_word  (instr_word),
        .instr_ready (instr_ready),
        .stages      (stages),
        .advance     (advance)
    );

    trace_unit u_trace (
        .clk       (clk),
        .rst       (rst),
        .enable    (enable),
        .stages    (stages),
        .advance   (advance),
        .rec_valid (rec_valid),
        .rec       (rec)
    );

    // records go straight in, the FIFO drops on overflow
    trace_fifo u_fifo (
        .clk        (clk),
        .rst        (rst),
        .push       (rec_valid),
        .push_rec   (rec),
        .pop        (pop),
        .clear      (clear),
        .head       (head),
        .level      (level),
        .empty      (empty),
        .drop_count (drop_count)
    );

    trace_apb u_apb (
        .clk        (clk),
        .rst        (rst),
        .req        (apb_req),
        .head       (head),
        .level      (level),
        .empty      (empty),
        .drop_count (drop_count),
        .rsp        (apb_rsp),
        .enable     (enable),
        .pop        (pop),
        .clear      (clear)
    );

endmodule

`default_nettype wire

// ==== sim/pipe_trace_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_trace_assert import pipe_trace_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     stall,
    input  wire logic     instr_ready,
    input  wire apb_req_t apb_req,
    input  wire apb_rsp_t apb_rsp
);

    // the feed is frozen together with the pipe
    ready_low_on_stall: assert property (@(posedge clk) disable iff (rst)
        stall |-> !instr_ready)
        else $error("instr_ready high during stall");

    // slave error only while psel and penable are both set
    slverr_in_access: assert property (@(posedge clk) disable iff (rst)
        apb_rsp.pslverr |-> (apb_req.psel && apb_req.penable))
        else $error("pslverr outside the access phase");

    // zero wait states
    ready_in_access: assert property (@(posedge clk) disable iff (rst)
        apb_req.penable |-> apb_rsp.pready)
        else $error("pready low during penable");

endmodule

bind pipe_trace_top pipe_trace_assert u_assert (
    .clk         (clk),
    .rst         (rst),
    .stall       (stall),
    .instr_ready (instr_ready),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp)
);

`default_nettype wire

// ==== sim/tb_pipe_trace.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pipe_trace import pipe_trace_pkg::*; ();

    localparam int RST_CYCLES     = 8;
    localparam int IDLE_CYCLES    = 40;
    localparam int CLEAN_CYCLES   = 8;
    localparam int ROUND_CYCLES   = 10;
    localparam int DRAIN_CYCLES   = 12;
    localparam int LONG_CYCLES    = 240;
    localparam int CLEAN_ROUNDS   = 4;
    localparam int STALL_ROUNDS   = 12;
    localparam int FLUSH_ROUNDS   = 12;
    localparam int APB_CYCLES     = 3;
    localparam int ROUND_READS    = 2 + 3 * FIFO_DEPTH;
    localparam int ALL_ROUNDS     = CLEAN_ROUNDS + STALL_ROUNDS + FLUSH_ROUNDS;
    localparam int TIMEOUT_CYCLES = 2 * (RST_CYCLES + IDLE_CYCLES + LONG_CYCLES
        + ALL_ROUNDS * (ROUND_CYCLES + DRAIN_CYCLES + APB_CYCLES * ROUND_READS)
        + 3 * DRAIN_CYCLES + 20 * APB_CYCLES);

    logic     clk;
    logic     rst;
    logic     stall;
    logic     flush;
    logic     instr_valid;
    instr_t   instr_word;
    apb_req_t apb_req;
    logic     instr_ready;
    apb_rsp_t apb_rsp;

    integer seed = 57358;

    // reference pipeline where each slot carries the stamps of its instruction
    cycle_t     m_cycle;
    seq_t       m_seq;
    logic       m_v [NUM_STAGES];
    seq_t       m_s [NUM_STAGES];
    instr_t     m_i [NUM_STAGES];
    cycle_t     m_st [NUM_STAGES][NUM_STAGES];
    logic       m_enable = 1'b0;
    drop_t      m_drops = '0;
    trace_rec_t exp_q [$];
    seq_t       last_seq;
    logic       have_last = 1'b0;

    pipe_trace_top dut0 (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .flush       (flush),
        .instr_valid (instr_valid),
        .instr_word  (instr_word),
        .apb_req     (apb_req),
        .instr_ready (instr_ready),
        .apb_rsp     (apb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("sim failed");
        $fatal(1, "watchdog expired before the tests finished");
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            $display("sim failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    function automatic logic pct_hit(input int pct);
        return ($unsigned($random(seed)) % 100) < pct;
    endfunction

    function automatic dwell_t clamp_dwell(input cycle_t from, input cycle_t to);
        cycle_t span;
        span = to - from;
        return (span > 16'd255) ? 8'hff : span[7:0];
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // reference model stepped once per clock edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic move_slot(input int dst, input int src, input cycle_t now);
        m_v[dst] = m_v[src];
        m_s[dst] = m_s[src];
        m_i[dst] = m_i[src];
        for (int k = 0; k < NUM_STAGES; k++) begin
            m_st[dst][k] = m_st[src][k];
        end
        m_st[dst][dst] = now;
    endtask

    task automatic model_edge();
        cycle_t     nxt;
        trace_rec_t r;
        nxt = m_cycle + 16'd1;
        if (!stall) begin
            // memory item lands in write-back and its record is complete
            if (m_v[ST_M]) begin
                r.seq          = m_s[ST_M];
                r.instr        = m_i[ST_M];
                r.fetch_cycle  = m_st[ST_M][ST_F];
                r.retire_cycle = nxt;
                r.dwell_f      = clamp_dwell(m_st[ST_M][ST_F], m_st[ST_M][ST_D]);
                r.dwell_d      = clamp_dwell(m_st[ST_M][ST_D], m_st[ST_M][ST_E]);
                r.dwell_e      = clamp_dwell(m_st[ST_M][ST_E], m_st[ST_M][ST_M]);
                r.dwell_m      = clamp_dwell(m_st[ST_M][ST_M], nxt);
                if (m_enable) begin
                    if (exp_q.size() < FIFO_DEPTH) begin
                        exp_q.push_back(r);
                    end else if (m_drops != 8'hff) begin
                        m_drops = m_drops + 8'd1;
                    end
                end
            end
            move_slot(ST_W, ST_M, nxt);
            move_slot(ST_M, ST_E, nxt);
            if (flush) begin
                m_v[ST_E] = 1'b0;
                m_v[ST_D] = 1'b0;
            end else begin
                move_slot(ST_E, ST_D, nxt);
                move_slot(ST_D, ST_F, nxt);
            end
            m_v[ST_F]        = instr_valid;
            m_s[ST_F]        = m_seq;
            m_i[ST_F]        = instr_word;
            m_st[ST_F][ST_F] = nxt;
            if (instr_valid) begin
                m_seq = m_seq + 8'd1;
            end
        end
        m_cycle = nxt;
    endtask

    always @(posedge clk) begin
        // the feed takes a word only while the pipe is not frozen
        check("instr_ready", 32'(instr_ready), 32'(!stall));
        if (rst) begin
            m_cycle = '0;
            m_seq   = '0;
            for (int k = 0; k < NUM_STAGES; k++) begin
                m_v[k] = 1'b0;
            end
        end else begin
            model_edge();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // APB access and stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err);
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= write;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= wdata;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic write_ctrl(input apb_data_t value);
        apb_data_t unused;
        logic      err;
        apb_access(1'b1, ADDR_CTRL, value, unused, err);
        check("ctrl.pslverr", 32'(err), 0);
    endtask

    task automatic expect_enable(input logic exp_en);
        apb_data_t d;
        logic      err;
        apb_access(1'b0, ADDR_CTRL, '0, d, err);
        check("ctrl.pslverr", 32'(err), 0);
        check("ctrl.enable", 32'(d[CTRL_EN_BIT]), 32'(exp_en));
    endtask

    task automatic expect_status(input logic [31:0] exp);
        apb_data_t d;
        logic      err;
        apb_access(1'b0, ADDR_STATUS, '0, d, err);
        check("status.pslverr", 32'(err), 0);
        check("status", d, exp);
    endtask

    task automatic expect_error_read(input string name, input apb_addr_t addr);
        apb_data_t d;
        logic      err;
        apb_access(1'b0, addr, '0, d, err);
        check({name, ".pslverr"}, 32'(err), 1);
        check({name, ".prdata"}, d, 0);
    endtask

    task automatic read_record(input logic clean);
        trace_rec_t exp_rec;
        apb_data_t  d0;
        apb_data_t  d1;
        apb_data_t  d2;
        logic       err;
        cycle_t     span;
        seq_t       step;
        int         sum;
        exp_rec = exp_q.pop_front();
        apb_access(1'b0, ADDR_REC0, '0, d0, err);
        check("rec0.pslverr", 32'(err), 0);
        check("rec0", d0, {exp_rec.seq, 8'h00, exp_rec.instr});
        apb_access(1'b0, ADDR_REC1, '0, d1, err);
        check("rec1.pslverr", 32'(err), 0);
        check("rec1", d1, {exp_rec.fetch_cycle, exp_rec.retire_cycle});
        apb_access(1'b0, ADDR_REC2, '0, d2, err);
        check("rec2.pslverr", 32'(err), 0);
        check("rec2", d2, {exp_rec.dwell_f, exp_rec.dwell_d, exp_rec.dwell_e, exp_rec.dwell_m});

        // stamps must add up unless one stage saturated
        span = d1[15:0] - d1[31:16];
        sum  = int'(d2[31:24]) + int'(d2[23:16]) + int'(d2[15:8]) + int'(d2[7:0]);
        if (d2[31:24] != 8'hff && d2[23:16] != 8'hff && d2[15:8] != 8'hff
                && d2[7:0] != 8'hff) begin
            check("dwell_sum", 32'(sum), 32'(span));
        end
        if (clean) begin
            check("retire_minus_fetch", 32'(span), 4);
            check("dwells", d2, 32'h01010101);
        end

        // retired ids only move forward
        step = d0[31:24] - last_seq;
        if (have_last) begin
            if (clean) begin
                check("seq_step", 32'(step), 1);
            end
            check("seq_backward", 32'(step == 8'd0 || step > 8'd127), 0);
        end
        last_seq  = d0[31:24];
        have_last = 1'b1;
    endtask

    task automatic run_traffic(input int cycles, input int stall_pct, input int flush_pct);
        repeat (cycles) begin
            @(posedge clk);
            instr_valid <= pct_hit(70);
            stall       <= pct_hit(stall_pct);
            flush       <= pct_hit(flush_pct);
            instr_word  <= instr_t'($random(seed));
        end
        @(posedge clk);
        instr_valid <= 1'b0;
        stall       <= 1'b0;
        flush       <= 1'b0;
        repeat (DRAIN_CYCLES) @(posedge clk);
    endtask

    task automatic trace_round(input int cycles, input int stall_pct, input int flush_pct,
                               input logic clean);
        int n;
        run_traffic(cycles, stall_pct, flush_pct);
        expect_status({16'h0000, m_drops, 4'h0, 4'(exp_q.size())});
        n = exp_q.size();
        repeat (n) read_record(clean);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        rst         = 1'b1;
        stall       = 1'b0;
        flush       = 1'b0;
        instr_valid = 1'b0;
        instr_word  = '0;
        apb_req     = '0;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // tracing is off after reset so nothing reaches the FIFO
        run_traffic(IDLE_CYCLES, 0, 0);
        expect_enable(1'b0);
        expect_status(32'h0);
        expect_error_read("rec0_empty", ADDR_REC0);
        expect_error_read("rec2_empty", ADDR_REC2);
        expect_error_read("unknown_addr", 5'h14);

        m_enable = 1'b1;
        write_ctrl(32'h1);
        expect_enable(1'b1);

        repeat (CLEAN_ROUNDS) trace_round(CLEAN_CYCLES, 0, 0, 1'b1);
        repeat (STALL_ROUNDS) trace_round(ROUND_CYCLES, 20, 0, 1'b0);
        repeat (FLUSH_ROUNDS) trace_round(ROUND_CYCLES, 20, 10, 1'b0);

        // overflow without reads and then clear
        run_traffic(LONG_CYCLES, 20, 10);
        expect_status({16'h0000, m_drops, 4'h0, 4'd8});
        write_ctrl(32'h3);
        exp_q.delete();
        m_drops = '0;
        expect_enable(1'b1);
        expect_status(32'h0);

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== pipe_trace.f ====
hw/pipe_trace_pkg.sv
hw/stage_pipe.sv
hw/trace_unit.sv
hw/trace_fifo.sv
hw/trace_apb.sv
hw/pipe_trace_top.sv
sim/pipe_trace_assert.sv
sim/tb_pipe_trace.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench, a $fatal gives a nonzero exit status
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_pipe_trace \
    -f pipe_trace.f \
    -o sim_pipe_trace

./obj_dir/sim_pipe_trace
